// ==== list.f ====
common/mmu_pkg.sv
hw/tlb.sv
hw/ptw_arbiter.sv
ptw/ptw.sv
hw/mmu_top.sv
testbench/mmu_checker.sv
testbench/tb_mmu.sv

// ==== Makefile ====
# Verilator build and run for the Sv32 MMU testbench

VERILATOR ?= verilator
TOP       ?= tb_mmu
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# The simulation output goes to stderr, the pass search reads the copy on stdout
run: $(SIM)
	$(SIM) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/mmu_stimulus.txt ====
# M paddr word = page-table word; C satp_ppn mxr paging_en; F = flush both TLBs
# I/D vaddr is_store exp_paddr exp_fault exp_reads name; B = I fields then D fields
# exp_reads counts the memory reads seen while that request is outstanding
M 080000004 20000401
M 080000008 280000CF
M 08000000C 280004CF
M 080001000 240000CF
M 080001004 24000447
M 080001008 24000849
M 08000100C 24000CC7
M 080001010 240010C5
M 080001014 24001401
C 80000 0 1
I 00400010 0 090000010 0 2 i_walk_4k
I 00400020 0 090000020 0 0 i_hit_4k
D 00812345 0 0a0012345 0 1 d_megapage
D 00834000 1 0a0034000 0 0 d_mega_hit_st
D 01000000 0 0 1 1 d_invalid
D 00404000 0 0 1 2 d_w_no_r
D 00c00000 0 0 1 1 d_mega_misalign
I 00403000 0 0 1 2 i_no_x
D 00401010 1 0 1 2 d_st_dirty_walk
D 00401008 0 090001008 0 2 d_ld_fill
D 00401008 1 0 1 0 d_st_dirty_hit
D 00405000 0 0 1 2 d_ptr_level2
D 00402004 0 0 1 2 d_xonly_no_mxr
C 80000 1 1
D 00402004 0 090002004 0 2 d_xonly_mxr
C 80000 0 1
F
B 00800100 0 0a0000100 0 1 i_both_mega 00403040 0 090003040 0 3 d_both_4k
D 00400123 0 090000123 0 2 d_walk_4k
D 00400456 0 090000456 0 0 d_hit_4k
F
D 00400456 0 090000456 0 2 d_after_flush
C 80000 0 0
D 12345678 1 012345678 0 0 d_bare
I fffff004 0 0fffff004 0 0 i_bare

// ==== testbench/tb_mmu.sv ====
`timescale 1ns/10ps

module tb_mmu;
    import mmu_pkg::*;

    localparam int    ACK_TIMEOUT = 200;
    localparam int    NAME_W      = 8 * 16;
    localparam string STIM_FILE   = "testbench/mmu_stimulus.txt";

    logic              clk = 1'b0;
    logic              rst_n;
    csr_cfg_t          cfg;
    logic              flush;
    logic              i_req;
    xlate_req_t        i_xreq;
    logic              i_ack;
    xlate_rsp_t        i_xrsp;
    logic              d_req;
    xlate_req_t        d_xreq;
    logic              d_ack;
    xlate_rsp_t        d_xrsp;
    logic              mem_req;
    paddr_t            mem_addr;
    logic              mem_ack = 1'b0;
    word_t             mem_rdata = '0;

    // Expected results handed to the checker with each request
    xlate_rsp_t        i_exp;
    xlate_rsp_t        d_exp;
    int                i_exp_reads;
    int                d_exp_reads;
    logic [NAME_W-1:0] i_name;
    logic [NAME_W-1:0] d_name;

    word_t             mem_image [paddr_t];
    int                mem_wait = 0;
    integer            seed;
    int                issued;
    int                timeouts;
    int                value_errors;
    int                checks;
    bit                abort;

    always #4 clk = ~clk;

    mmu_top i_mmu_top (
        .clk, .rst_n, .cfg_i(cfg), .flush_i(flush),
        .i_req_i(i_req), .i_xreq_i(i_xreq), .i_ack_o(i_ack), .i_xrsp_o(i_xrsp),
        .d_req_i(d_req), .d_xreq_i(d_xreq), .d_ack_o(d_ack), .d_xrsp_o(d_xrsp),
        .mem_req_o(mem_req), .mem_addr_o(mem_addr), .mem_ack_i(mem_ack),
        .mem_rdata_i(mem_rdata)
    );

    mmu_checker #(.NAME_W(NAME_W)) i_mmu_checker (
        .clk, .rst_n,
        .i_req_i(i_req), .i_ack_i(i_ack), .i_xrsp_i(i_xrsp),
        .i_exp_i(i_exp), .i_exp_reads_i(i_exp_reads), .i_name_i(i_name),
        .d_req_i(d_req), .d_ack_i(d_ack), .d_xrsp_i(d_xrsp),
        .d_exp_i(d_exp), .d_exp_reads_i(d_exp_reads), .d_name_i(d_name),
        .mem_req_i(mem_req), .errors_o(value_errors), .checks_o(checks)
    );

    function automatic word_t read_word(input paddr_t addr);
        if (mem_image.exists(addr)) begin
            return mem_image[addr];
        end
        // Unmapped words read as invalid entries
        return '0;
    endfunction

    // Page-table memory, replies one to four cycles after req is seen
    always @(posedge clk) begin
        if (mem_ack) begin
            if (!mem_req) begin
                mem_ack <= 1'b0;
            end
        end else if (mem_req) begin
            if (mem_wait == 0) begin
                mem_ack   <= 1'b1;
                mem_rdata <= read_word(mem_addr);
            end else begin
                mem_wait <= mem_wait - 1;
            end
        end else begin
            mem_wait <= int'($unsigned($random(seed)) % 4);
        end
    end

    function automatic logic port_ack(input bit is_d);
        return is_d ? d_ack : i_ack;
    endfunction

    task automatic scan_xlate(input int fd, output xlate_req_t req, output xlate_rsp_t exp,
                              output int reads, output logic [NAME_W-1:0] name);
        vaddr_t va;
        paddr_t pa;
        int     st;
        int     flt;
        int     code;
        code = $fscanf(fd, "%h %d %h %d %d %s", va, st, pa, flt, reads, name);
        if (code != 6) begin
            $display("Malformed translation line in the stimulus file");
            abort = 1'b1;
        end
        req = '{vaddr: va, is_store: st[0]};
        exp = '{paddr: pa, page_fault: flt[0]};
    endtask

    task automatic drive_xlate(input bit is_d, input xlate_req_t req, input xlate_rsp_t exp,
                               input int reads, input logic [NAME_W-1:0] name);
        int waited;
        @(posedge clk);
        if (is_d) begin
            d_exp       <= exp;
            d_exp_reads <= reads;
            d_name      <= name;
            d_xreq      <= req;
            d_req       <= 1'b1;
        end else begin
            i_exp       <= exp;
            i_exp_reads <= reads;
            i_name      <= name;
            i_xreq      <= req;
            i_req       <= 1'b1;
        end
        issued = issued + 1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!port_ack(is_d) && (waited < ACK_TIMEOUT));
        if (!port_ack(is_d)) begin
            $display("Timeout: ack never rose on port %s during %0s", is_d ? "D" : "I", name);
            timeouts++;
            abort = 1'b1;
            return;
        end
        if (is_d) begin
            d_req <= 1'b0;
        end else begin
            i_req <= 1'b0;
        end
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (port_ack(is_d) && (waited < ACK_TIMEOUT));
        if (port_ack(is_d)) begin
            $display("Timeout: ack never fell on port %s during %0s", is_d ? "D" : "I", name);
            timeouts++;
            abort = 1'b1;
        end
    endtask

    initial begin
        int                fd;
        int                code;
        int                mxr;
        int                en;
        logic [31:0]       cmd;
        logic [8*128-1:0]  line_buf;
        paddr_t            addr;
        word_t             data;
        ppn_t              ppn;
        xlate_req_t        i_rq;
        xlate_req_t        d_rq;
        xlate_rsp_t        i_ex;
        xlate_rsp_t        d_ex;
        int                i_rd;
        int                d_rd;
        logic [NAME_W-1:0] i_nm;
        logic [NAME_W-1:0] d_nm;
        seed        = 32'h7c52_7639;
        rst_n       = 1'b0;
        cfg         = '0;
        flush       = 1'b0;
        i_req       = 1'b0;
        i_xreq      = '0;
        d_req       = 1'b0;
        d_xreq      = '0;
        i_exp       = '0;
        d_exp       = '0;
        i_exp_reads = 0;
        d_exp_reads = 0;
        i_name      = '0;
        d_name      = '0;
        issued      = 0;
        timeouts    = 0;
        abort       = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        // Quiet window after reset, watched by the checker
        repeat (4) @(posedge clk);
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file %s", STIM_FILE);
            abort = 1'b1;
        end
        while (!abort) begin
            code = $fscanf(fd, "%s", cmd);
            if (code != 1) begin
                break;
            end
            if (cmd == "#") begin
                code = $fgets(line_buf, fd);
            end else if (cmd == "M") begin
                code = $fscanf(fd, "%h %h", addr, data);
                mem_image[addr] = data;
            end else if (cmd == "C") begin
                code = $fscanf(fd, "%h %d %d", ppn, mxr, en);
                @(posedge clk);
                cfg <= '{satp_ppn: ppn, mxr: mxr[0], paging_en: en[0]};
            end else if (cmd == "F") begin
                @(posedge clk);
                flush <= 1'b1;
                @(posedge clk);
                flush <= 1'b0;
            end else if ((cmd == "I") || (cmd == "D")) begin
                scan_xlate(fd, i_rq, i_ex, i_rd, i_nm);
                if (!abort) begin
                    drive_xlate(cmd == "D", i_rq, i_ex, i_rd, i_nm);
                end
            end else if (cmd == "B") begin
                scan_xlate(fd, i_rq, i_ex, i_rd, i_nm);
                scan_xlate(fd, d_rq, d_ex, d_rd, d_nm);
                if (!abort) begin
                    fork
                        drive_xlate(1'b0, i_rq, i_ex, i_rd, i_nm);
                        drive_xlate(1'b1, d_rq, d_ex, d_rd, d_nm);
                    join
                end
            end else begin
                $display("Unknown command %0s in the stimulus file", cmd);
                abort = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        repeat (4) @(posedge clk);
        if (checks != issued) begin
            $display("Only %0d of %0d translations reached the checker", checks, issued);
        end
        $display("Checks: %0d of %0d, value errors: %0d, timeouts: %0d",
                 checks, issued, value_errors, timeouts);
        if ((value_errors == 0) && (timeouts == 0) && !abort && (issued > 0)
            && (checks == issued)) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== testbench/mmu_checker.sv ====
`timescale 1ns/10ps

module mmu_checker #(
    parameter int NAME_W = 128
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_req_i,
    input  logic                i_ack_i,
    input  mmu_pkg::xlate_rsp_t i_xrsp_i,
    input  mmu_pkg::xlate_rsp_t i_exp_i,
    input  int                  i_exp_reads_i,
    input  logic [NAME_W-1:0]   i_name_i,
    input  logic                d_req_i,
    input  logic                d_ack_i,
    input  mmu_pkg::xlate_rsp_t d_xrsp_i,
    input  mmu_pkg::xlate_rsp_t d_exp_i,
    input  int                  d_exp_reads_i,
    input  logic [NAME_W-1:0]   d_name_i,
    input  logic                mem_req_i,
    output int                  errors_o,
    output int                  checks_o
);
    import mmu_pkg::*;

    logic started;
    logic i_req_q;
    logic i_ack_q;
    logic d_req_q;
    logic d_ack_q;
    logic mem_req_q;
    int   i_lat;
    int   d_lat;
    // Memory reads seen while each request is outstanding
    int   i_reads;
    int   d_reads;

    task automatic compare_result(input logic [NAME_W-1:0] name, input xlate_rsp_t exp,
                                  input xlate_rsp_t got, input int exp_reads,
                                  input int reads, input int lat);
        checks_o = checks_o + 1;
        if (got.page_fault !== exp.page_fault) begin
            $display("[ERROR] %0s: page fault expected %0b actual %0b",
                     name, exp.page_fault, got.page_fault);
            errors_o = errors_o + 1;
        end else if (!exp.page_fault && (got.paddr !== exp.paddr)) begin
            $display("[ERROR] %0s: paddr expected %h actual %h", name, exp.paddr, got.paddr);
            errors_o = errors_o + 1;
        end
        if (reads != exp_reads) begin
            $display("[ERROR] %0s: memory reads expected %0d actual %0d", name, exp_reads, reads);
            errors_o = errors_o + 1;
        end
        // Hits and untranslated accesses answer one cycle after req
        if ((exp_reads == 0) && (lat != 1)) begin
            $display("[ERROR] %0s: ack latency expected 1 actual %0d", name, lat);
            errors_o = errors_o + 1;
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            started   <= 1'b0;
            i_req_q   <= 1'b0;
            i_ack_q   <= 1'b0;
            d_req_q   <= 1'b0;
            d_ack_q   <= 1'b0;
            mem_req_q <= 1'b0;
            i_lat     <= 0;
            d_lat     <= 0;
            i_reads   <= 0;
            d_reads   <= 0;
            errors_o  = 0;
            checks_o  = 0;
        end else begin
            i_req_q   <= i_req_i;
            i_ack_q   <= i_ack_i;
            d_req_q   <= d_req_i;
            d_ack_q   <= d_ack_i;
            mem_req_q <= mem_req_i;
            if (i_req_i || d_req_i) begin
                started <= 1'b1;
            end else if (!started && (i_ack_i || d_ack_i || mem_req_i)) begin
                $display("An ack or memory request went high before the first request");
                errors_o = errors_o + 1;
            end
            if (i_req_i && !i_req_q) begin
                i_lat   <= 0;
                i_reads <= 0;
            end else if (i_ack_i && !i_ack_q) begin
                compare_result(i_name_i, i_exp_i, i_xrsp_i, i_exp_reads_i, i_reads, i_lat + 1);
            end else begin
                i_lat <= i_lat + 1;
                if (mem_req_i && !mem_req_q && i_req_i && !i_ack_i) begin
                    i_reads <= i_reads + 1;
                end
            end
            if (d_req_i && !d_req_q) begin
                d_lat   <= 0;
                d_reads <= 0;
            end else if (d_ack_i && !d_ack_q) begin
                compare_result(d_name_i, d_exp_i, d_xrsp_i, d_exp_reads_i, d_reads, d_lat + 1);
            end else begin
                d_lat <= d_lat + 1;
                if (mem_req_i && !mem_req_q && d_req_i && !d_ack_i) begin
                    d_reads <= d_reads + 1;
                end
            end
        end
    end

endmodule

// ==== hw/mmu_top.sv ====
`timescale 1ns/10ps

module mmu_top (
    input  logic                clk,
    input  logic                rst_n,
    input  mmu_pkg::csr_cfg_t   cfg_i,
    input  logic                flush_i,
    input  logic                i_req_i,
    input  mmu_pkg::xlate_req_t i_xreq_i,
    output logic                i_ack_o,
    output mmu_pkg::xlate_rsp_t i_xrsp_o,
    input  logic                d_req_i,
    input  mmu_pkg::xlate_req_t d_xreq_i,
    output logic                d_ack_o,
    output mmu_pkg::xlate_rsp_t d_xrsp_o,
    output logic                mem_req_o,
    output mmu_pkg::paddr_t     mem_addr_o,
    input  logic                mem_ack_i,
    input  mmu_pkg::word_t      mem_rdata_i
);
    import mmu_pkg::*;

    // Instruction TLB to arbiter
    logic      i_walk_req;
    walk_req_t i_walk;
    logic      i_walk_ack;
    walk_rsp_t i_walk_rsp;

    // Data TLB to arbiter
    logic      d_walk_req;
    walk_req_t d_walk;
    logic      d_walk_ack;
    walk_rsp_t d_walk_rsp;

    // Arbiter to walker
    logic      walk_req;
    walk_req_t walk;
    logic      walk_ack;
    walk_rsp_t walk_rsp;

    tlb #(.IS_INSTR(1'b1)) i_itlb (
        .clk, .rst_n, .cfg_i, .flush_i,
        .req_i(i_req_i), .xreq_i(i_xreq_i), .ack_o(i_ack_o), .xrsp_o(i_xrsp_o),
        .walk_req_o(i_walk_req), .walk_o(i_walk),
        .walk_ack_i(i_walk_ack), .walk_rsp_i(i_walk_rsp)
    );

    tlb #(.IS_INSTR(1'b0)) i_dtlb (
        .clk, .rst_n, .cfg_i, .flush_i,
        .req_i(d_req_i), .xreq_i(d_xreq_i), .ack_o(d_ack_o), .xrsp_o(d_xrsp_o),
        .walk_req_o(d_walk_req), .walk_o(d_walk),
        .walk_ack_i(d_walk_ack), .walk_rsp_i(d_walk_rsp)
    );

    ptw_arbiter i_ptw_arbiter (
        .clk, .rst_n,
        .i_walk_req_i(i_walk_req), .i_walk_i(i_walk),
        .i_walk_ack_o(i_walk_ack), .i_walk_rsp_o(i_walk_rsp),
        .d_walk_req_i(d_walk_req), .d_walk_i(d_walk),
        .d_walk_ack_o(d_walk_ack), .d_walk_rsp_o(d_walk_rsp),
        .walk_req_o(walk_req), .walk_o(walk),
        .walk_ack_i(walk_ack), .walk_rsp_i(walk_rsp)
    );

    ptw i_ptw (
        .clk, .rst_n, .cfg_i,
        .walk_req_i(walk_req), .walk_i(walk), .walk_ack_o(walk_ack), .walk_rsp_o(walk_rsp),
        .mem_req_o, .mem_addr_o, .mem_ack_i, .mem_rdata_i
    );

endmodule

// ==== ptw/ptw.sv ====
`timescale 1ns/10ps

module ptw (
    input  logic               clk,
    input  logic               rst_n,
    input  mmu_pkg::csr_cfg_t  cfg_i,
    input  logic               walk_req_i,
    input  mmu_pkg::walk_req_t walk_i,
    output logic               walk_ack_o,
    output mmu_pkg::walk_rsp_t walk_rsp_o,
    output logic               mem_req_o,
    output mmu_pkg::paddr_t    mem_addr_o,
    input  logic               mem_ack_i,
    input  mmu_pkg::word_t     mem_rdata_i
);
    import mmu_pkg::*;

    ptw_state_e state_q;
    // Current page-table level (1 or 2)
    logic [1:0] level_q;
    walk_req_t  walk_q;
    pte_sv32_t  pte_q;
    logic       start_walk;
    logic       pte_bad;
    logic       pte_leaf;
    logic       mega_misaligned;
    logic       leaf_ok;
    logic       descend;
    logic       fault;

    assign start_walk = (state_q == IDLE) && walk_req_i && !mem_ack_i;

    // PTE decode used in CHECK
    assign pte_bad         = !pte_q.v || (pte_q.w && !pte_q.r);
    assign pte_leaf        = pte_q.r || pte_q.x;
    assign mega_misaligned = (level_q == 2'd1) && (pte_q.ppn[9:0] != '0);
    assign leaf_ok         = leaf_permits(pte_q, walk_q.is_instr, walk_q.is_store, cfg_i.mxr)
                             && !mega_misaligned;
    assign descend         = !pte_bad && !pte_leaf && (level_q == 2'd1);

    // A pointer at level 2 has nowhere left to go
    assign fault = pte_bad || (pte_leaf && !leaf_ok) || (!pte_leaf && (level_q == 2'd2));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= IDLE;
            level_q    <= 2'd1;
            mem_req_o  <= 1'b0;
            walk_ack_o <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_walk) begin
                        level_q   <= 2'd1;
                        mem_req_o <= 1'b1;
                        state_q   <= MEM_REQ;
                    end
                end
                MEM_REQ: begin
                    // Stalls here for as long as memory is slow
                    if (mem_ack_i) begin
                        mem_req_o <= 1'b0;
                        state_q   <= MEM_RELEASE;
                    end
                end
                MEM_RELEASE: begin
                    if (!mem_ack_i) begin
                        state_q <= CHECK;
                    end
                end
                CHECK: begin
                    if (descend) begin
                        level_q   <= 2'd2;
                        mem_req_o <= 1'b1;
                        state_q   <= MEM_REQ;
                    end else begin
                        walk_ack_o <= 1'b1;
                        state_q    <= RESPOND;
                    end
                end
                RESPOND: begin
                    if (!walk_req_i) begin
                        walk_ack_o <= 1'b0;
                        state_q    <= RELEASE;
                    end
                end
                RELEASE: begin
                    // One idle cycle lets the arbiter drop its lock
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_walk) begin
            walk_q     <= walk_i;
            // Level-1 entry at satp.ppn indexed by VPN[1]
            mem_addr_o <= {cfg_i.satp_ppn, walk_i.vaddr[31:22], 2'b00};
        end
        if ((state_q == MEM_REQ) && mem_ack_i) begin
            pte_q <= mem_rdata_i;
        end
        if (state_q == CHECK) begin
            if (descend) begin
                mem_addr_o <= {pte_q.ppn, walk_q.vaddr[21:12], 2'b00};
            end else begin
                walk_rsp_o <= '{pte: pte_q, megapage: (level_q == 2'd1), page_fault: fault};
            end
        end
    end

    a_mem_req_after_ack_low: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_req_o) |-> !$past(mem_ack_i));

    // A read either starts a walk or descends from level 1
    a_level_range: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_req_o) |-> ((level_q == 2'd1) || ($past(level_q) == 2'd1)));

endmodule

// ==== hw/ptw_arbiter.sv ====
`timescale 1ns/10ps

module ptw_arbiter (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               i_walk_req_i,
    input  mmu_pkg::walk_req_t i_walk_i,
    output logic               i_walk_ack_o,
    output mmu_pkg::walk_rsp_t i_walk_rsp_o,
    input  logic               d_walk_req_i,
    input  mmu_pkg::walk_req_t d_walk_i,
    output logic               d_walk_ack_o,
    output mmu_pkg::walk_rsp_t d_walk_rsp_o,
    output logic               walk_req_o,
    output mmu_pkg::walk_req_t walk_o,
    input  logic               walk_ack_i,
    input  mmu_pkg::walk_rsp_t walk_rsp_i
);
    import mmu_pkg::*;

    logic lock_q;
    logic owner_d_q;
    // High when the data TLB owns the walker
    logic sel_d;

    // Instruction side wins whenever the grant is free
    assign sel_d = lock_q ? owner_d_q : (d_walk_req_i && !i_walk_req_i);

    assign walk_req_o = sel_d ? d_walk_req_i : i_walk_req_i;
    assign walk_o     = sel_d ? d_walk_i : i_walk_i;

    assign i_walk_ack_o = !sel_d && walk_ack_i;
    assign d_walk_ack_o = sel_d && walk_ack_i;
    assign i_walk_rsp_o = sel_d ? walk_rsp_t'('0) : walk_rsp_i;
    assign d_walk_rsp_o = sel_d ? walk_rsp_i : walk_rsp_t'('0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lock_q    <= 1'b0;
            owner_d_q <= 1'b0;
        end else begin
            if (!lock_q && walk_req_o) begin
                lock_q    <= 1'b1;
                owner_d_q <= sel_d;
            end else if (lock_q && !walk_req_o && !walk_ack_i) begin
                // Handshake fully closed, grant is free again
                lock_q <= 1'b0;
            end
        end
    end

    a_grant_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(walk_req_o || walk_ack_i) && (walk_req_o || walk_ack_i))
        |-> (sel_d == $past(sel_d)));

endmodule

// ==== hw/tlb.sv ====
`timescale 1ns/10ps

module tlb #(
    parameter bit IS_INSTR = 1'b0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  mmu_pkg::csr_cfg_t   cfg_i,
    input  logic                flush_i,
    input  logic                req_i,
    input  mmu_pkg::xlate_req_t xreq_i,
    output logic                ack_o,
    output mmu_pkg::xlate_rsp_t xrsp_o,
    output logic                walk_req_o,
    output mmu_pkg::walk_req_t  walk_o,
    input  logic                walk_ack_i,
    input  mmu_pkg::walk_rsp_t  walk_rsp_i
);
    import mmu_pkg::*;

    typedef enum logic [1:0] {
        T_IDLE,
        T_WALK,
        T_ACK
    } tlb_state_e;

    tlb_state_e             state_q;
    logic [TLB_ENTRIES-1:0] ent_valid;
    vpn_t                   ent_vpn  [TLB_ENTRIES];
    logic                   ent_mega [TLB_ENTRIES];
    pte_sv32_t              ent_pte  [TLB_ENTRIES];
    logic [TLB_IDX_W-1:0]   victim_q;
    logic [TLB_IDX_W-1:0]   hit_idx;
    logic [TLB_ENTRIES-1:0] match;
    vpn_t                   req_vpn;
    logic                   hit;
    logic                   hit_ok;
    logic                   start_req;
    logic                   walk_done;
    logic                   fill_en;

    function automatic paddr_t make_paddr(input ppn_t ppn, input logic mega, input vaddr_t va);
        // Megapage keeps VPN[0] from the virtual address
        if (mega) begin
            return {ppn[21:10], va[21:0]};
        end
        return {ppn, va[PAGE_OFFSET-1:0]};
    endfunction

    assign req_vpn = xreq_i.vaddr[VALEN-1:PAGE_OFFSET];

    always_comb begin
        match   = '0;
        hit_idx = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (ent_mega[i]) begin
                match[i] = ent_valid[i] && (ent_vpn[i][19:10] == req_vpn[19:10]);
            end else begin
                match[i] = ent_valid[i] && (ent_vpn[i] == req_vpn);
            end
            if (match[i]) begin
                hit_idx = TLB_IDX_W'(i);
            end
        end
    end

    assign hit       = |match;
    assign hit_ok    = leaf_permits(ent_pte[hit_idx], IS_INSTR, xreq_i.is_store, cfg_i.mxr);
    assign start_req = (state_q == T_IDLE) && req_i;
    assign walk_done = (state_q == T_WALK) && walk_ack_i;
    assign fill_en   = walk_done && !walk_rsp_i.page_fault;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= T_IDLE;
            ack_o      <= 1'b0;
            walk_req_o <= 1'b0;
            ent_valid  <= '0;
            victim_q   <= '0;
        end else begin
            case (state_q)
                T_IDLE: begin
                    if (req_i && (!cfg_i.paging_en || hit)) begin
                        ack_o   <= 1'b1;
                        state_q <= T_ACK;
                    end else if (req_i && !walk_ack_i) begin
                        // Previous walk handshake must be fully closed first
                        walk_req_o <= 1'b1;
                        state_q    <= T_WALK;
                    end
                end
                T_WALK: begin
                    if (walk_ack_i) begin
                        walk_req_o <= 1'b0;
                        ack_o      <= 1'b1;
                        state_q    <= T_ACK;
                    end
                end
                default: begin
                    if (!req_i) begin
                        ack_o   <= 1'b0;
                        state_q <= T_IDLE;
                    end
                end
            endcase
            if (fill_en) begin
                ent_valid[victim_q] <= 1'b1;
                victim_q            <= victim_q + 1'b1;
            end
            if (flush_i) begin
                ent_valid <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_req) begin
            walk_o <= '{vaddr: xreq_i.vaddr, is_instr: IS_INSTR, is_store: xreq_i.is_store};
            if (!cfg_i.paging_en) begin
                xrsp_o <= '{paddr: PALEN'(xreq_i.vaddr), page_fault: 1'b0};
            end else if (hit_ok) begin
                xrsp_o <= '{paddr: make_paddr(ent_pte[hit_idx].ppn, ent_mega[hit_idx],
                                              xreq_i.vaddr),
                            page_fault: 1'b0};
            end else begin
                xrsp_o <= '{paddr: '0, page_fault: 1'b1};
            end
        end
        if (walk_done) begin
            xrsp_o.paddr      <= make_paddr(walk_rsp_i.pte.ppn, walk_rsp_i.megapage, walk_o.vaddr);
            xrsp_o.page_fault <= walk_rsp_i.page_fault;
        end
        if (fill_en) begin
            ent_vpn[victim_q]  <= walk_o.vaddr[VALEN-1:PAGE_OFFSET];
            ent_mega[victim_q] <= walk_rsp_i.megapage;
            ent_pte[victim_q]  <= walk_rsp_i.pte;
        end
    end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack_o) |-> $past(req_i));

    // Fills only happen after a miss, so tags never overlap
    a_single_match: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(match));

endmodule

// ==== common/mmu_pkg.sv ====
package mmu_pkg;

    // Sv32 widths
    localparam int XLEN        = 32;
    localparam int VALEN       = 32;
    localparam int PALEN       = 34;
    localparam int PAGE_OFFSET = 12;

    // TLB geometry
    localparam int TLB_ENTRIES = 4;
    localparam int TLB_IDX_W   = $clog2(TLB_ENTRIES);

    typedef logic [VALEN-1:0]             vaddr_t;
    typedef logic [PALEN-1:0]             paddr_t;
    typedef logic [VALEN-PAGE_OFFSET-1:0] vpn_t;
    typedef logic [PALEN-PAGE_OFFSET-1:0] ppn_t;
    typedef logic [XLEN-1:0]              word_t;

    // Page-table entry, bit 0 is V
    typedef struct packed {
        ppn_t       ppn;
        logic [1:0] rsw;
        logic       d;
        logic       a;
        logic       g;
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_sv32_t;

    typedef struct packed {
        ppn_t satp_ppn;
        logic mxr;
        logic paging_en;
    } csr_cfg_t;

    typedef struct packed {
        vaddr_t vaddr;
        logic   is_store;
    } xlate_req_t;

    typedef struct packed {
        paddr_t paddr;
        logic   page_fault;
    } xlate_rsp_t;

    typedef struct packed {
        vaddr_t vaddr;
        logic   is_instr;
        logic   is_store;
    } walk_req_t;

    typedef struct packed {
        pte_sv32_t pte;
        logic      megapage;
        logic      page_fault;
    } walk_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        MEM_REQ,
        MEM_RELEASE,
        CHECK,
        RESPOND,
        RELEASE
    } ptw_state_e;

    // Access rule for a leaf entry, shared by walker and TLB hit path
    function automatic logic leaf_permits(input pte_sv32_t pte, input logic is_instr,
                                          input logic is_store, input logic mxr);
        logic ok;
        if (is_instr) begin
            ok = pte.x && pte.a;
        end else begin
            ok = pte.a && (pte.r || (pte.x && mxr));
            // Stores also need a writable page already marked dirty
            if (is_store) begin
                ok = ok && pte.w && pte.d;
            end
        end
        return ok;
    endfunction

endpackage
